//--- rtl/cart_mem.sv
`timescale 1ns/100ps

module cart_mem #(
	parameter int AW = mem_pkg::MEM_AW
) (
	input  logic              m2,
	input  mem_pkg::mem_req_t req,
	output logic [7:0]        rdat
);

	// prg in the lower half, chr in the upper half
	logic [7:0] mem [2**AW];

	always_ff @(posedge m2) begin
		if (req.valid) begin
			if (req.we)
				mem[req.addr[AW-1:0]] <= req.wdat;
			rdat <= mem[req.addr[AW-1:0]];   // old contents on a write
		end
	end

endmodule

//--- rtl/cart_top.sv
`timescale 1ns/100ps

module cart_top (
	input  logic              m2,
	input  logic              map_rst,
	input  map_pkg::map_cfg_t cfg,
	input  map_pkg::cpu_bus_t cpu,
	input  map_pkg::ppu_bus_t ppu,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [11:0]       paddr,
	input  logic [7:0]        pwdata,
	output logic [7:0]        prdata,
	output logic              pready,
	output logic              cpu_ack,
	output logic [7:0]        cpu_rdat,
	output logic              ppu_ack,
	output logic [7:0]        ppu_rdat,
	output logic              ciram_a10,
	output logic              ciram_ce,
	output logic              irq
);

	localparam int N_REQ = 3;
	localparam int AW = mem_pkg::MEM_AW;

	mem_pkg::mem_req_t arb_req [N_REQ];   // indexed by requester
	mem_pkg::mem_req_t mem_req;
	logic [N_REQ-1:0]  arb_ack;
	logic [7:0]        arb_rdat;
	logic [7:0]        mem_rdat;
	map_pkg::ss_bus_t  ss;
	logic [7:0]        ss_rdat;
	logic              cpu_reg_ack;

	map_142 map_142_i (
		.m2          (m2),
		.map_rst     (map_rst),
		.cfg         (cfg),
		.cpu         (cpu),
		.ppu         (ppu),
		.ss          (ss),
		.ss_rdat     (ss_rdat),
		.cpu_mreq    (arb_req[mem_pkg::SRC_CPU]),
		.ppu_mreq    (arb_req[mem_pkg::SRC_PPU]),
		.cpu_reg_ack (cpu_reg_ack),
		.ciram_a10   (ciram_a10),
		.ciram_ce    (ciram_ce),
		.irq         (irq)
	);

	mem_arbiter #(.N_REQ(N_REQ)) mem_arbiter_i (
		.m2       (m2),
		.map_rst  (map_rst),
		.req_in   (arb_req),
		.ack      (arb_ack),
		.rdat     (arb_rdat),
		.mem_req  (mem_req),
		.mem_rdat (mem_rdat)
	);

	cart_mem #(.AW(AW)) cart_mem_i (
		.m2   (m2),
		.req  (mem_req),
		.rdat (mem_rdat)
	);

	host_apb host_apb_i (
		.m2      (m2),
		.map_rst (map_rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.ss      (ss),
		.ss_rdat (ss_rdat),
		.mreq    (arb_req[mem_pkg::SRC_HOST]),
		.mack    (arb_ack[mem_pkg::SRC_HOST]),
		.mrdat   (arb_rdat)
	);

	// register writes are acked by the mapper, reads by the arbiter
	assign cpu_ack = cpu_reg_ack | arb_ack[mem_pkg::SRC_CPU];
	assign cpu_rdat = arb_rdat;
	assign ppu_ack = arb_ack[mem_pkg::SRC_PPU];
	assign ppu_rdat = arb_rdat;

endmodule

//--- rtl/host_apb.sv
`timescale 1ns/100ps

module host_apb (
	input  logic              m2,
	input  logic              map_rst,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [11:0]       paddr,
	input  logic [7:0]        pwdata,
	output logic [7:0]        prdata,
	output logic              pready,
	output map_pkg::ss_bus_t  ss,
	input  logic [7:0]        ss_rdat,
	output mem_pkg::mem_req_t mreq,
	input  logic              mack,
	input  logic [7:0]        mrdat
);

	logic                       acc;       // access phase
	logic                       sel_reg;
	logic                       sel_page;
	logic                       sel_win;
	logic [9:0]                 page;
	logic                       ld_pend;
	logic [mem_pkg::MEM_AW-1:0] ld_addr;
	logic                       ld_we;
	logic [7:0]                 ld_wdat;

	assign acc = psel && penable;
	assign sel_reg = !paddr[11];
	assign sel_page = paddr[11:1] == 11'h400;   // 0x800 low byte, 0x801 top two bits
	assign sel_win = paddr[11:8] == 4'h9;

	assign ss = '{
		ss_act:  acc && sel_reg,
		ss_we:   acc && sel_reg && pwrite,
		ss_addr: paddr[7:0],
		ss_wdat: pwdata
	};

	assign mreq = '{addr: ld_addr, we: ld_we, wdat: ld_wdat, valid: ld_pend};

	// loader window waits for memory, everything else finishes at once
	assign pready = acc && (sel_win ? mack : 1'b1);

	always_comb begin
		if (sel_reg)
			prdata = ss_rdat;
		else if (sel_win)
			prdata = mrdat;
		else if (sel_page)
			prdata = paddr[0] ? {6'd0, page[9:8]} : page[7:0];
		else
			prdata = 8'h00;
	end

	always_ff @(posedge m2) begin
		if (map_rst) begin
			page <= 10'd0;
			ld_pend <= 1'b0;
		end else begin
			if (acc && pwrite && sel_page) begin
				if (paddr[0])
					page[9:8] <= pwdata[1:0];
				else
					page[7:0] <= pwdata;
			end
			if (acc && sel_win && !ld_pend)
				ld_pend <= 1'b1;
			else if (mack)
				ld_pend <= 1'b0;
		end
	end

	always_ff @(posedge m2) begin
		if (acc && sel_win && !ld_pend) begin
			ld_addr <= {page, paddr[7:0]};
			ld_we <= pwrite;
			ld_wdat <= pwdata;
		end
	end

	a_paddr_hold: assert property (@(posedge m2) disable iff (map_rst)
		psel && !pready |=> $stable(paddr));

endmodule

//--- rtl/map_142.sv
`timescale 1ns/100ps

module map_142 (
	input  logic              m2,
	input  logic              map_rst,
	input  map_pkg::map_cfg_t cfg,
	input  map_pkg::cpu_bus_t cpu,
	input  map_pkg::ppu_bus_t ppu,
	input  map_pkg::ss_bus_t  ss,
	output logic [7:0]        ss_rdat,
	output mem_pkg::mem_req_t cpu_mreq,
	output mem_pkg::mem_req_t ppu_mreq,
	output logic              cpu_reg_ack,
	output logic              ciram_a10,
	output logic              ciram_ce,
	output logic              irq
);

	logic [3:0]  prg_bank [4];
	logic [3:0]  prg_sel;       // bank select written at $e000
	logic [7:0]  chr_bank [8];
	logic        mirror;
	logic [15:0] irq_counter;
	logic [15:0] irq_latch;
	logic        irq_enable;
	logic        irq_reg;
	logic        reg_wr;
	logic [3:0]  cpu_bank;

	// cpu writes never go to memory, the mapper takes and acks them
	assign reg_wr = cpu.req && !cpu.cpu_rw && !cpu_reg_ack && !ss.ss_act;

	assign cpu_bank = cpu.cpu_ce ? prg_bank[3] : prg_bank[cpu.cpu_addr[14:13]];

	assign cpu_mreq = '{
		addr:  {mem_pkg::REGION_PRG, cpu_bank, cpu.cpu_addr[12:0]},
		we:    1'b0,
		wdat:  8'h00,
		valid: cpu.req && cpu.cpu_rw
	};

	// nametable fetches go to ciram, only pattern space is requested
	assign ppu_mreq = '{
		addr:  {mem_pkg::REGION_CHR, 3'b000, chr_bank[0][0], ppu.ppu_addr[12:0]},
		we:    1'b0,
		wdat:  8'h00,
		valid: ppu.req && !ppu.ppu_addr[13]
	};

	assign ciram_a10 = cfg.cfg_mir_v ? ppu.ppu_addr[10] : ppu.ppu_addr[11];
	assign ciram_ce = !ppu.ppu_addr[13];
	assign irq = irq_reg;

	always_ff @(posedge m2) begin
		if (map_rst)
			cpu_reg_ack <= 1'b0;
		else
			cpu_reg_ack <= reg_wr;   // one cycle after the write
	end

	always_ff @(posedge m2) begin
		if (map_rst) begin
			for (int i = 0; i < 4; i++)
				prg_bank[i] <= 4'(i);
			for (int i = 0; i < 8; i++)
				chr_bank[i] <= 8'h00;
			prg_sel <= 4'd0;
			mirror <= 1'b0;
			irq_counter <= 16'h0000;
			irq_latch <= 16'h0000;
			irq_enable <= 1'b0;
			irq_reg <= 1'b0;
		end else if (ss.ss_act) begin
			// state restore, everything else holds
			if (ss.ss_we) begin
				if (ss.ss_addr[7:3] == 5'd0)
					chr_bank[ss.ss_addr[2:0]] <= ss.ss_wdat;
				if (ss.ss_addr[7:2] == map_pkg::SS_IDX_PRG[7:2])
					prg_bank[ss.ss_addr[1:0]] <= ss.ss_wdat[3:0];
				case (ss.ss_addr)
					map_pkg::SS_IDX_CTRL:        {mirror, irq_reg, irq_enable} <= ss.ss_wdat[7:5];
					map_pkg::SS_IDX_CNT:         irq_counter[7:0] <= ss.ss_wdat;
					map_pkg::SS_IDX_CNT + 8'd1:  irq_counter[15:8] <= ss.ss_wdat;
					map_pkg::SS_IDX_LAT:         irq_latch[7:0] <= ss.ss_wdat;
					map_pkg::SS_IDX_LAT + 8'd1:  irq_latch[15:8] <= ss.ss_wdat;
					default: ;
				endcase
			end
		end else begin
			if (reg_wr && !cpu.cpu_ce) begin
				case (cpu.cpu_addr[14:12])
					3'd0, 3'd1, 3'd2, 3'd3: begin   // latch nibbles
						irq_latch[{cpu.cpu_addr[13:12], 2'b00} +: 4] <= cpu.cpu_dat[3:0];
						irq_reg <= 1'b0;
					end
					3'd4: begin
						irq_enable <= cpu.cpu_dat[3:0] != 4'd0;
						if (cpu.cpu_dat[3:0] != 4'd0)
							irq_counter <= irq_latch;
						irq_reg <= 1'b0;
					end
					3'd5: irq_reg <= 1'b0;            // acknowledge
					3'd6: prg_sel <= cpu.cpu_dat[3:0];
					3'd7: begin
						case (prg_sel)
							4'd1: prg_bank[0] <= cpu.cpu_dat[3:0];
							4'd2: prg_bank[1] <= cpu.cpu_dat[3:0];
							4'd3: prg_bank[2] <= cpu.cpu_dat[3:0];
							4'd4: prg_bank[3] <= cpu.cpu_dat[3:0];
							default: ;
						endcase
					end
				endcase
			end

			// up counter, fires on the wrap and restarts from the latch
			if (irq_enable) begin
				if (irq_counter == 16'hffff) begin
					irq_counter <= irq_latch;
					irq_reg <= 1'b1;
				end else begin
					irq_counter <= irq_counter + 16'd1;
				end
			end
		end
	end

	always_comb begin
		ss_rdat = 8'hff;
		if (ss.ss_addr[7:3] == 5'd0) begin
			ss_rdat = chr_bank[ss.ss_addr[2:0]];
		end else if (ss.ss_addr[7:2] == map_pkg::SS_IDX_PRG[7:2]) begin
			ss_rdat = {4'd0, prg_bank[ss.ss_addr[1:0]]};
		end else begin
			case (ss.ss_addr)
				map_pkg::SS_IDX_CTRL:       ss_rdat = {mirror, irq_reg, irq_enable, 5'd0};
				map_pkg::SS_IDX_CNT:        ss_rdat = irq_counter[7:0];
				map_pkg::SS_IDX_CNT + 8'd1: ss_rdat = irq_counter[15:8];
				map_pkg::SS_IDX_LAT:        ss_rdat = irq_latch[7:0];
				map_pkg::SS_IDX_LAT + 8'd1: ss_rdat = irq_latch[15:8];
				map_pkg::SS_IDX_MAP:        ss_rdat = map_pkg::MAP_NUM;
				default:                    ss_rdat = 8'hff;
			endcase
		end
	end

	// the cpu must hold its write until the ack, so no read can appear with it
	a_no_mreq_on_reg_ack: assert property (@(posedge m2) disable iff (map_rst)
		cpu_reg_ack |-> !cpu_mreq.valid);

endmodule

//--- rtl/map_pkg.sv
package map_pkg;

	// cpu side of the cartridge connector
	typedef struct packed {
		logic [14:0] cpu_addr;
		logic        cpu_ce;   // low for $8000 and up
		logic        cpu_rw;   // 1 = read
		logic [7:0]  cpu_dat;
		logic        req;
	} cpu_bus_t;

	// ppu side, pattern and nametable fetches
	typedef struct packed {
		logic [13:0] ppu_addr;
		logic        ppu_we;   // active low
		logic        req;
	} ppu_bus_t;

	typedef struct packed {
		logic cfg_mir_v;     // vertical mirroring
		logic cfg_chr_ram;   // chr is ram instead of rom
	} map_cfg_t;

	// save-state port
	typedef struct packed {
		logic       ss_act;
		logic       ss_we;
		logic [7:0] ss_addr;
		logic [7:0] ss_wdat;
	} ss_bus_t;

	// save-state register map
	localparam logic [7:0] SS_IDX_PRG  = 8'd8;    // four prg banks from here
	localparam logic [7:0] SS_IDX_CTRL = 8'd12;
	localparam logic [7:0] SS_IDX_CNT  = 8'd13;   // counter lo, hi
	localparam logic [7:0] SS_IDX_LAT  = 8'd15;   // latch lo, hi
	localparam logic [7:0] SS_IDX_MAP  = 8'd127;

	localparam logic [7:0] MAP_NUM = 8'd142;

endpackage

//--- rtl/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter #(
	parameter int N_REQ = 3
) (
	input  logic              m2,
	input  logic              map_rst,
	input  mem_pkg::mem_req_t req_in [N_REQ],
	output logic [N_REQ-1:0]  ack,
	output logic [7:0]        rdat,
	output mem_pkg::mem_req_t mem_req,
	input  logic [7:0]        mem_rdat
);

	localparam int IW = (N_REQ > 1) ? $clog2(N_REQ) : 1;

	logic [IW-1:0] rr_ptr;    // first in line this cycle
	logic [IW-1:0] gnt_idx;
	logic          gnt_vld;
	logic [IW-1:0] fl_idx;    // grant whose data comes back now
	logic          fl_vld;

	always_comb begin
		int j;
		gnt_vld = 1'b0;
		gnt_idx = '0;
		for (int k = 0; k < N_REQ; k++) begin
			j = int'(rr_ptr) + k;
			if (j >= N_REQ)
				j = j - N_REQ;
			// a requester waiting for its ack still shows valid, skip it
			if (!gnt_vld && req_in[j].valid && !(fl_vld && fl_idx == IW'(j))) begin
				gnt_vld = 1'b1;
				gnt_idx = IW'(j);
			end
		end
	end

	always_comb begin
		mem_req = req_in[gnt_idx];
		mem_req.valid = gnt_vld;
	end

	always_ff @(posedge m2) begin
		if (map_rst) begin
			rr_ptr <= '0;
			fl_vld <= 1'b0;
			fl_idx <= '0;
		end else begin
			fl_vld <= gnt_vld;
			fl_idx <= gnt_idx;
			if (gnt_vld)
				rr_ptr <= (gnt_idx == IW'(N_REQ - 1)) ? '0 : gnt_idx + 1'b1;
		end
	end

	always_comb begin
		for (int i = 0; i < N_REQ; i++)
			ack[i] = fl_vld && fl_idx == IW'(i);
	end

	assign rdat = fl_vld ? mem_rdat : 8'h00;

	a_one_ack: assert property (@(posedge m2) disable iff (map_rst)
		$onehot0(ack));

	// an ack answers that requester's request of the cycle before and never comes twice in a row
	for (genvar i = 0; i < N_REQ; i++) begin : g_ack_chk
		a_ack_after_gnt: assert property (@(posedge m2) disable iff (map_rst)
			ack[i] |-> $past(req_in[i].valid) && !$past(ack[i]));
	end

endmodule

//--- rtl/mem_pkg.sv
package mem_pkg;

	// 17 bits of prg space plus the region bit
	localparam int MEM_AW = 18;

	// top address bit picks the region
	localparam logic REGION_PRG = 1'b0;
	localparam logic REGION_CHR = 1'b1;

	// one request into cartridge memory
	typedef struct packed {
		logic [MEM_AW-1:0] addr;
		logic              we;
		logic [7:0]        wdat;
		logic              valid;
	} mem_req_t;

	// arbiter port numbering
	typedef enum logic [1:0] {
		SRC_CPU  = 2'd0,
		SRC_PPU  = 2'd1,
		SRC_HOST = 2'd2
	} req_src_e;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the cartridge testbench, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cart_tb -Mdir obj_dir -f vlog.f \
	&& ./obj_dir/Vcart_tb 2>&1 | tee sim.log
grep -qF '*** PASSED ***' sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }

//--- sim/cart_tb.sv
`timescale 1ns/100ps

module cart_tb;

	typedef enum logic [2:0] {
		OP_APB_WR,
		OP_APB_RD,
		OP_CPU_WR,
		OP_CPU_RD,
		OP_PPU_RD,
		OP_IRQ     // data = cycles until irq rises, 0 = level check against exp[0]
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  exp;
	} entry_t;

	localparam int CLK_HALF = 20;
	localparam int ACK_LIMIT = 32;
	localparam int IRQ_WAIT = 256;   // irq count plus the contention block

	logic              m2;
	logic              map_rst;
	map_pkg::map_cfg_t cfg;
	map_pkg::cpu_bus_t cpu;
	map_pkg::ppu_bus_t ppu;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [11:0]       paddr;
	logic [7:0]        pwdata;
	logic [7:0]        prdata;
	logic              pready;
	logic              cpu_ack;
	logic [7:0]        cpu_rdat;
	logic              ppu_ack;
	logic [7:0]        ppu_rdat;
	logic              ciram_a10;
	logic              ciram_ce;
	logic              irq;

	entry_t      tbl [$];
	logic [31:0] rng = 32'h5320_085c;
	int          wd_cycles = 0;
	logic [15:0] ct_addr [3];   // cpu, ppu, apb address of the contention reads
	logic [7:0]  ct_data [3];
	logic [7:0]  ct_got [3];

	cart_top cart_top_i (
		.m2        (m2),
		.map_rst   (map_rst),
		.cfg       (cfg),
		.cpu       (cpu),
		.ppu       (ppu),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.cpu_ack   (cpu_ack),
		.cpu_rdat  (cpu_rdat),
		.ppu_ack   (ppu_ack),
		.ppu_rdat  (ppu_rdat),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce),
		.irq       (irq)
	);

	always #CLK_HALF m2 = ~m2;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			abort_run($sformatf("error %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_irq(input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("error irq: got %h, expected %h", got, exp));
	endtask

	task automatic check_line(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("error %s: got %h, expected %h", name, got, exp));
	endtask

	function automatic logic [7:0] rand_byte();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng[23:16];
	endfunction

	function automatic logic ack_of(input op_e op);
		case (op)
			OP_APB_WR, OP_APB_RD: return pready;
			OP_CPU_WR, OP_CPU_RD: return cpu_ack;
			default:              return ppu_ack;
		endcase
	endfunction

	// samples on the falling edge, away from the drive edge
	task automatic wait_ack(input op_e op);
		int n;
		n = 0;
		@(negedge m2);
		while (!ack_of(op)) begin
			n++;
			if (n > ACK_LIMIT)
				abort_run($sformatf("%s saw no handshake within %0d cycles",
					op.name(), ACK_LIMIT));
			@(negedge m2);
		end
	endtask

	task automatic apb_xfer(input logic wr, input logic [11:0] a, input logic [7:0] d,
			output logic [7:0] rd);
		@(posedge m2);
		psel <= 1'b1;        // setup phase
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= a;
		pwdata <= d;
		@(posedge m2);
		penable <= 1'b1;
		wait_ack(OP_APB_RD);
		rd = prdata;
		@(posedge m2);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// bit 15 of a set means cpu_ce low
	task automatic cpu_xfer(input logic wr, input logic [15:0] a, input logic [7:0] d,
			output logic [7:0] rd);
		@(posedge m2);
		cpu.cpu_addr <= a[14:0];
		cpu.cpu_ce <= !a[15];
		cpu.cpu_rw <= !wr;
		cpu.cpu_dat <= d;
		cpu.req <= 1'b1;
		wait_ack(OP_CPU_RD);
		rd = cpu_rdat;
		@(posedge m2);
		cpu.req <= 1'b0;
	endtask

	task automatic ppu_xfer(input logic [13:0] a, input logic mir_v, output logic [7:0] rd);
		@(posedge m2);
		ppu.ppu_addr <= a;
		ppu.ppu_we <= 1'b1;
		ppu.req <= !a[13];      // nametable fetches never reach cartridge memory
		cfg.cfg_mir_v <= mir_v;
		if (a[13])
			@(negedge m2);
		else
			wait_ack(OP_PPU_RD);
		rd = ppu_rdat;
		check_line("ciram_a10", ciram_a10, mir_v ? a[10] : a[11]);
		check_line("ciram_ce", ciram_ce, !a[13]);
		@(posedge m2);
		ppu.req <= 1'b0;
	endtask

	function automatic void add(input op_e op, input logic [15:0] a, input logic [7:0] d,
			input logic [7:0] x);
		tbl.push_back('{op: op, addr: a, data: d, exp: x});
	endfunction

	// page low, page high, then the byte through the window
	function automatic void add_load(input logic [17:0] ma, input logic [7:0] d);
		add(OP_APB_WR, 16'h0800, ma[15:8], 8'h00);
		add(OP_APB_WR, 16'h0801, {6'd0, ma[17:16]}, 8'h00);
		add(OP_APB_WR, {8'h09, ma[7:0]}, d, 8'h00);
	endfunction

	function automatic void build_table();
		logic [3:0]  banks [4];
		logic [7:0]  ss_val [17];
		logic [12:0] off;
		logic [17:0] ma;
		logic [7:0]  hi;
		logic [7:0]  d;
		logic [7:0]  x;

		banks = '{4'd5, 4'd9, 4'd12, 4'd14};

		// reset defaults
		add(OP_IRQ, 16'd0, 8'd0, 8'd0);
		for (int i = 0; i < 4; i++)
			add(OP_APB_RD, 16'(8 + i), 8'd0, 8'(i));
		add(OP_APB_RD, 16'd12, 8'd0, 8'h00);
		add(OP_APB_RD, 16'd127, 8'd0, 8'h8e);

		// prg banking, byte at bank * 8k + offset
		for (int i = 0; i < 4; i++) begin
			add(OP_CPU_WR, 16'he000, 8'(i + 1), 8'd0);
			add(OP_CPU_WR, 16'hf000, {4'd0, banks[i]}, 8'd0);
			add(OP_APB_RD, 16'(8 + i), 8'd0, {4'd0, banks[i]});
			hi = rand_byte();
			off = {hi[4:0], rand_byte()};
			d = rand_byte();
			ma = {1'b0, banks[i], off};
			add_load(ma, d);
			add(OP_APB_RD, {8'h09, ma[7:0]}, 8'd0, d);   // loader read back
			add(OP_CPU_RD, 16'h8000 + 16'(i) * 16'h2000 + 16'(off), 8'd0, d);
			if (i == 3)
				add(OP_CPU_RD, 16'h6000 + 16'(off), 8'd0, d);
		end

		// chr reads, chr bank 0 still 0, both mirroring modes
		for (int i = 0; i < 4; i++) begin
			hi = rand_byte();
			off = {hi[4:0], rand_byte()};
			d = rand_byte();
			add_load({1'b1, 4'd0, off}, d);
			add(OP_PPU_RD, {3'd0, off}, 8'(i & 1), d);
		end
		add(OP_PPU_RD, 16'h2c00, 8'd1, 8'd0);
		add(OP_PPU_RD, 16'h2800, 8'd0, 8'd0);
		add(OP_PPU_RD, 16'h2400, 8'd0, 8'd0);
		add(OP_PPU_RD, 16'h2400, 8'd1, 8'd0);

		// latch fff0 by nibbles, irq after 10000 - fff0 cycles
		add(OP_CPU_WR, 16'h8000, 8'h00, 8'd0);
		add(OP_CPU_WR, 16'h9000, 8'h0f, 8'd0);
		add(OP_CPU_WR, 16'ha000, 8'h0f, 8'd0);
		add(OP_CPU_WR, 16'hb000, 8'h0f, 8'd0);
		add(OP_APB_RD, 16'd15, 8'd0, 8'hf0);
		add(OP_APB_RD, 16'd16, 8'd0, 8'hff);
		add(OP_CPU_WR, 16'hc000, 8'h01, 8'd0);
		add(OP_IRQ, 16'd0, 8'(17'h10000 - 17'h0fff0), 8'd0);
		add(OP_CPU_WR, 16'hd000, 8'h00, 8'd0);
		add(OP_IRQ, 16'd0, 8'd0, 8'd0);
		add(OP_CPU_WR, 16'hc000, 8'h00, 8'd0);
		add(OP_APB_RD, 16'd12, 8'd0, 8'h00);   // enable and irq both off

		// save-state write then read back
		for (int i = 0; i < 17; i++) begin
			ss_val[i] = rand_byte();
			if (i == 12)
				ss_val[i][5] = 1'b0;   // irq enable stays off so the counter holds
			add(OP_APB_WR, 16'(i), ss_val[i], 8'd0);
		end
		for (int i = 0; i < 17; i++) begin
			x = ss_val[i];
			if (i >= 8 && i < 12)
				x = x & 8'h0f;     // prg banks are 4 bits
			else if (i == 12)
				x = x & 8'he0;
			add(OP_APB_RD, 16'(i), 8'd0, x);
		end
		add(OP_APB_RD, 16'd17, 8'd0, 8'hff);
		add(OP_APB_RD, 16'd64, 8'd0, 8'hff);
		add(OP_APB_RD, 16'd127, 8'd0, 8'h8e);
		add(OP_APB_RD, 16'hfe, 8'd0, 8'hff);

		// bytes for the contention reads, host byte last so the page stays
		hi = rand_byte();
		off = {hi[4:0], rand_byte()};
		for (int i = 0; i < 3; i++)
			ct_data[i] = rand_byte();
		add_load({1'b0, ss_val[8][3:0], off}, ct_data[0]);
		add_load({1'b1, 3'd0, ss_val[0][0], off}, ct_data[1]);
		add_load({1'b1, 3'd0, !ss_val[0][0], off}, ct_data[2]);
		ct_addr[0] = 16'h8000 + 16'(off);
		ct_addr[1] = {3'd0, off};
		ct_addr[2] = {8'h09, off[7:0]};
	endfunction

	task automatic run_entry(input int i, input entry_t e);
		logic [7:0] rd;
		int         k;
		case (e.op)
			OP_APB_WR: apb_xfer(1'b1, e.addr[11:0], e.data, rd);
			OP_APB_RD: begin
				apb_xfer(1'b0, e.addr[11:0], 8'h00, rd);
				check_byte($sformatf("prdata [%0d]", i), rd, e.exp);
			end
			OP_CPU_WR: cpu_xfer(1'b1, e.addr, e.data, rd);
			OP_CPU_RD: begin
				cpu_xfer(1'b0, e.addr, 8'h00, rd);
				check_byte($sformatf("cpu_rdat [%0d]", i), rd, e.exp);
			end
			OP_PPU_RD: begin
				ppu_xfer(e.addr[13:0], e.data[0], rd);
				if (!e.addr[13])
					check_byte($sformatf("ppu_rdat [%0d]", i), rd, e.exp);
			end
			default: begin
				@(negedge m2);
				if (e.data == 8'd0) begin
					check_irq(irq, e.exp[0]);
				end else begin
					k = 1;   // first falling edge is one cycle after the enable
					while (!irq && k < 255) begin
						@(negedge m2);
						k++;
					end
					check_byte("irq delay", 8'(k), e.data);
				end
			end
		endcase
	endtask

	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge m2);
		abort_run($sformatf("watchdog expired after %0d cycles", wd_cycles));
	end

	initial begin
		m2 = 1'b0;
		map_rst = 1'b1;
		cfg = '0;
		cpu = '0;
		cpu.cpu_ce = 1'b1;
		cpu.cpu_rw = 1'b1;
		ppu = '0;
		ppu.ppu_we = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		build_table();
		wd_cycles = tbl.size() * 64 + IRQ_WAIT;
		repeat (3) @(posedge m2);
		map_rst <= 1'b0;

		for (int i = 0; i < tbl.size(); i++)
			run_entry(i, tbl[i]);

		// all three requests valid in the same cycle
		fork
			begin
				repeat (2) @(posedge m2);
				cpu_xfer(1'b0, ct_addr[0], 8'h00, ct_got[0]);
			end
			begin
				repeat (2) @(posedge m2);
				ppu_xfer(ct_addr[1][13:0], 1'b1, ct_got[1]);
			end
			apb_xfer(1'b0, ct_addr[2][11:0], 8'h00, ct_got[2]);
		join
		check_byte("cpu_rdat contention", ct_got[0], ct_data[0]);
		check_byte("ppu_rdat contention", ct_got[1], ct_data[1]);
		check_byte("prdata contention", ct_got[2], ct_data[2]);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- vlog.f
rtl/map_pkg.sv
rtl/mem_pkg.sv
rtl/map_142.sv
rtl/mem_arbiter.sv
rtl/cart_mem.sv
rtl/host_apb.sv
rtl/cart_top.sv
sim/cart_tb.sv
